/* Bender.yml */
package:
  name: fp_adder

sources:
  - files:
      - src/fpFormatPkg.sv
      - src/fpAddCtrlPkg.sv
      - src/fpAddControl.sv
      - src/alignShiftCounter.sv
      - src/operandUnpack.sv
      - src/mantissaAligner.sv
      - src/mantissaAddSub.sv
      - src/resultNormalize.sv
      - src/fpAdder.sv
  - target: simulation
    files:
      - verif/fpAdder_checker.sv
      - verif/fpAdderTb.sv

/* files.f */
src/fpFormatPkg.sv
src/fpAddCtrlPkg.sv
src/fpAddControl.sv
src/alignShiftCounter.sv
src/operandUnpack.sv
src/mantissaAligner.sv
src/mantissaAddSub.sv
src/resultNormalize.sv
src/fpAdder.sv
verif/fpAdder_checker.sv
verif/fpAdderTb.sv

/* src/alignShiftCounter.sv */
// Alignment shift down-counter with zero detect
`timescale 1ns/1ns
`default_nettype none

module alignShiftCounter (
    input  logic       clk,
    input  logic       rst,
    input  logic       loadCount,
    input  logic       shiftEn,
    input  logic [4:0] shiftAmount,
    output logic       countZero
);

    logic [4:0] count;
    logic [4:0] nextCount;

    always_comb
    begin
        if (loadCount)
            nextCount = shiftAmount;
        else if (shiftEn && (count != '0))
            nextCount = count - 5'd1;
        else
            nextCount = count;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            count <= '0;
        else
            count <= nextCount;
    end

    // Looks at the count after this cycle so ALIGN lasts exactly shiftAmount cycles
    assign countZero = (nextCount == '0);

endmodule

`default_nettype wire

/* src/fpAddControl.sv */
// Adder sequencing FSM with busy and done generation
`timescale 1ns/1ns
`default_nettype none

module fpAddControl
    import fpAddCtrlPkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  logic         countZero,
    output ctrlStrobes_t strobes,
    output logic         busy,
    output logic         done
);

    addState_t state;
    addState_t nextState;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
            done  <= 1'b0;
        end
        else
        begin
            state <= nextState;
            // Result register loads on the same edge
            done  <= (state == NORM);
        end
    end

    always_comb
    begin
        nextState = state;
        strobes   = '0;
        case (state)
            IDLE:
            begin
                // Start is dropped during the done cycle too
                if (start && !done)
                begin
                    strobes.loadOps = 1'b1;
                    nextState       = UNPACK;
                end
            end
            UNPACK:
            begin
                strobes.loadCount = 1'b1;
                // Equal exponents need no alignment
                nextState = countZero ? ADD : ALIGN;
            end
            ALIGN:
            begin
                strobes.shiftEn = 1'b1;
                if (countZero)
                    nextState = ADD;
            end
            ADD:
            begin
                strobes.addEn = 1'b1;
                nextState     = NORM;
            end
            NORM:
            begin
                strobes.normEn = 1'b1;
                nextState      = IDLE;
            end
            default:
                nextState = IDLE;
        endcase
    end

    // Held through the done cycle
    assign busy = (state != IDLE) || done;

endmodule

`default_nettype wire

/* src/fpAddCtrlPkg.sv */
// Adder controller state encoding and control strobe bundle
`default_nettype none

package fpAddCtrlPkg;

    // Sequencer states, one per datapath step
    typedef enum logic [2:0] {
        IDLE,
        UNPACK,
        ALIGN,
        ADD,
        NORM
    } addState_t;

    // Strobes from the controller to the data stages
    typedef struct packed {
        // Capture operands on the start edge
        logic loadOps;
        // Load shift counter and aligner
        logic loadCount;
        // One alignment step
        logic shiftEn;
        // Register the sum
        logic addEn;
        // Register the rounded result
        logic normEn;
    } ctrlStrobes_t;

endpackage

`default_nettype wire

/* src/fpAdder.sv */
// Top level of the multi-cycle single-precision adder and subtractor
`timescale 1ns/1ns
`default_nettype none

module fpAdder
    import fpFormatPkg::*, fpAddCtrlPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  fpWord_t opA,
    input  fpWord_t opB,
    input  logic    subtract,
    output fpWord_t result,
    output logic    busy,
    output logic    done
);

    ctrlStrobes_t strobes;
    logic         countZero;
    logic [4:0]   shiftAmount;
    unpacked_t    larger;
    logic [23:0]  smallerMant;
    logic         smallerSign;
    alignedPair_t aligned;
    sumResult_t   sum;

    fpAddControl u_control (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .countZero (countZero),
        .strobes   (strobes),
        .busy      (busy),
        .done      (done)
    );

    alignShiftCounter u_shiftCounter (
        .clk         (clk),
        .rst         (rst),
        .loadCount   (strobes.loadCount),
        .shiftEn     (strobes.shiftEn),
        .shiftAmount (shiftAmount),
        .countZero   (countZero)
    );

    operandUnpack u_unpack (
        .clk         (clk),
        .rst         (rst),
        .loadOps     (strobes.loadOps),
        .subtract    (subtract),
        .opA         (opA),
        .opB         (opB),
        .larger      (larger),
        .smallerMant (smallerMant),
        .smallerSign (smallerSign),
        .shiftAmount (shiftAmount)
    );

    // Aligner picks up the unpacked pair in UNPACK, one cycle after capture
    mantissaAligner u_aligner (
        .clk         (clk),
        .rst         (rst),
        .loadOps     (strobes.loadCount),
        .shiftEn     (strobes.shiftEn),
        .larger      (larger),
        .smallerMant (smallerMant),
        .smallerSign (smallerSign),
        .aligned     (aligned)
    );

    mantissaAddSub u_addSub (
        .clk     (clk),
        .rst     (rst),
        .addEn   (strobes.addEn),
        .aligned (aligned),
        .sum     (sum)
    );

    resultNormalize u_normalize (
        .clk    (clk),
        .rst    (rst),
        .normEn (strobes.normEn),
        .sum    (sum),
        .result (result)
    );

endmodule

`default_nettype wire

/* src/fpFormatPkg.sv */
// IEEE single-precision field layout, operand word union and datapath stage structs
`default_nettype none

package fpFormatPkg;

    // IEEE-754 binary32 layout, sign in the top bit
    typedef struct packed {
        logic       sign;
        logic [7:0] exponent;
        logic [22:0] fraction;
    } fpFields_t;

    // Same 32-bit word seen either as raw bits or as decoded fields
    typedef union packed {
        logic [31:0] raw;
        fpFields_t   fields;
    } fpWord_t;

    // Larger operand after unpacking, hidden bit restored
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [23:0] mant;
    } unpacked_t;

    // Operand pair lined up on a common exponent
    // Exponent carries a spare top bit for the carry-out and rounding increments
    typedef struct packed {
        logic [23:0] largeMant;
        logic [25:0] smallMant;
        logic        sticky;
        logic [8:0]  exponent;
        logic        sign;
        logic        effSub;
    } alignedPair_t;

    // Magnitude is 24 mantissa bits followed by guard, round and sticky
    typedef struct packed {
        logic [26:0] mag;
        logic [8:0]  exponent;
        logic        sign;
    } sumResult_t;

    // Beyond this the smaller mantissa only feeds sticky
    localparam int unsigned alignLimit = 26;

endpackage

`default_nettype wire

/* src/mantissaAddSub.sv */
// Magnitude adder and subtractor with carry-out renormalization
`timescale 1ns/1ns
`default_nettype none

module mantissaAddSub
    import fpFormatPkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         addEn,
    input  alignedPair_t aligned,
    output sumResult_t   sum
);

    logic [26:0] largeMag;
    logic [26:0] smallMag;
    logic [27:0] rawSum;

    always_comb
    begin
        largeMag = {aligned.largeMant, 3'b000};
        smallMag = {aligned.smallMant, aligned.sticky};
        // Larger magnitude comes first, so the difference never goes negative
        if (aligned.effSub)
            rawSum = {1'b0, largeMag} - {1'b0, smallMag};
        else
            rawSum = {1'b0, largeMag} + {1'b0, smallMag};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            sum <= '0;
        else if (addEn)
        begin
            if (rawSum[27])
            begin
                // Carry out, drop one place and keep the lost bit in sticky
                sum.mag      <= {rawSum[27:2], rawSum[1] | rawSum[0]};
                sum.exponent <= aligned.exponent + 9'd1;
            end
            else
            begin
                sum.mag      <= rawSum[26:0];
                sum.exponent <= aligned.exponent;
            end
            sum.sign <= aligned.sign;
        end
    end

endmodule

`default_nettype wire

/* src/mantissaAligner.sv */
// Serial right shifter for the smaller mantissa with guard, round and sticky
`timescale 1ns/1ns
`default_nettype none

module mantissaAligner
    import fpFormatPkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         loadOps,
    input  logic         shiftEn,
    input  unpacked_t    larger,
    input  logic [23:0]  smallerMant,
    input  logic         smallerSign,
    output alignedPair_t aligned
);

    always_ff @(posedge clk)
    begin
        if (rst)
            aligned <= '0;
        else if (loadOps)
        begin
            aligned.largeMant <= larger.mant;
            // Guard and round start out empty
            aligned.smallMant <= {smallerMant, 2'b00};
            aligned.sticky    <= 1'b0;
            aligned.exponent  <= {1'b0, larger.exponent};
            // Larger magnitude decides the result sign
            aligned.sign      <= larger.sign;
            aligned.effSub    <= larger.sign ^ smallerSign;
        end
        else if (shiftEn)
        begin
            aligned.smallMant <= aligned.smallMant >> 1;
            // Whatever falls off the round bit is kept as sticky
            aligned.sticky    <= aligned.sticky | aligned.smallMant[0];
        end
    end

endmodule

`default_nettype wire

/* src/operandUnpack.sv */
// Operand decode, denormal flush, magnitude compare, swap and capped exponent difference
`timescale 1ns/1ns
`default_nettype none

module operandUnpack
    import fpFormatPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        loadOps,
    input  logic        subtract,
    input  fpWord_t     opA,
    input  fpWord_t     opB,
    output unpacked_t   larger,
    output logic [23:0] smallerMant,
    output logic        smallerSign,
    output logic [4:0]  shiftAmount
);

    fpFields_t  aIn;
    fpFields_t  bIn;
    logic       aSign;
    logic       bSign;
    logic [23:0] aMant;
    logic [23:0] bMant;
    logic       aLarger;
    logic [7:0] expDiff;
    logic [4:0] cappedDiff;

    always_comb
    begin
        aIn   = opA.fields;
        bIn   = opB.fields;
        aSign = aIn.sign;
        // Subtraction is addition of B with its sign flipped
        bSign = bIn.sign ^ subtract;
        // Exponent zero means zero here, denormals included
        aMant = (aIn.exponent == '0) ? '0 : {1'b1, aIn.fraction};
        bMant = (bIn.exponent == '0) ? '0 : {1'b1, bIn.fraction};
        // Exponent first, then mantissa; ties keep A on top
        aLarger = {aIn.exponent, aMant} >= {bIn.exponent, bMant};
        expDiff = aLarger ? (aIn.exponent - bIn.exponent) : (bIn.exponent - aIn.exponent);
        cappedDiff = (expDiff > alignLimit) ? 5'(alignLimit) : expDiff[4:0];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            shiftAmount <= '0;
        else if (loadOps)
            shiftAmount <= cappedDiff;
    end

    always_ff @(posedge clk)
    begin
        if (loadOps)
        begin
            larger.sign     <= aLarger ? aSign : bSign;
            larger.exponent <= aLarger ? aIn.exponent : bIn.exponent;
            larger.mant     <= aLarger ? aMant : bMant;
            smallerMant     <= aLarger ? bMant : aMant;
            smallerSign     <= aLarger ? bSign : aSign;
        end
    end

endmodule

`default_nettype wire

/* src/resultNormalize.sv */
// Leading-zero normalize, round to nearest even, overflow and underflow, result register
`timescale 1ns/1ns
`default_nettype none

module resultNormalize
    import fpFormatPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       normEn,
    input  sumResult_t sum,
    output fpWord_t    result
);

    logic [4:0]         leadZeros;
    logic [26:0]        normMag;
    logic               roundUp;
    logic [24:0]        rounded;
    logic signed [10:0] adjExp;
    logic signed [10:0] finalExp;
    fpWord_t            nextResult;

    // Position of the first one below the hidden-bit slot
    function automatic logic [4:0] countLeadZeros(input logic [26:0] mag);
        logic [4:0] zeros;
        zeros = 5'd27;
        for (int i = 0; i <= 26; i++)
        begin
            if (mag[i])
                zeros = 5'(26 - i);
        end
        return zeros;
    endfunction

    always_comb
    begin
        leadZeros = countLeadZeros(sum.mag);
        normMag   = sum.mag << leadZeros;
        adjExp    = $signed({2'b00, sum.exponent}) - $signed({6'b000000, leadZeros});

        // Nearest even from guard, with round, sticky or an odd lsb
        roundUp  = normMag[2] & (normMag[1] | normMag[0] | normMag[3]);
        rounded  = {1'b0, normMag[26:3]} + {24'd0, roundUp};
        // Mantissa wrapped to 10.0...0, so bump the exponent
        finalExp = adjExp + $signed({10'd0, rounded[24]});

        nextResult.fields.sign     = sum.sign;
        nextResult.fields.exponent = finalExp[7:0];
        // A rounding wrap leaves the fraction bits all zero
        nextResult.fields.fraction = rounded[22:0];

        if ((sum.mag == '0) || (finalExp < 11'sd1))
            nextResult.raw = '0;
        else if (finalExp >= 11'sd255)
        begin
            // Signed infinity
            nextResult.fields.exponent = 8'hff;
            nextResult.fields.fraction = '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            result.raw <= '0;
        else if (normEn)
            result <= nextResult;
    end

endmodule

`default_nettype wire

/* verif/fpAdderTb.sv */
// Testbench for fpAdder with clock, reset, reference model, directed and random tests, report
`timescale 1ns/1ns
`default_nettype none

module fpAdderTb;

    import fpFormatPkg::*;

    localparam int resetCycles = 8;
    localparam int opTotal     = 220;
    localparam int cycleLimit  = opTotal * 40 + resetCycles;

    logic    clk;
    logic    rst;
    logic    start;
    logic    subtract;
    fpWord_t opA;
    fpWord_t opB;
    fpWord_t result;
    logic    busy;
    logic    done;

    int          errors;
    int          opsRun;
    int          testsRun;
    int          cycleCount;
    logic [31:0] rngState;

    fpAdder u_fpAdder (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .opA      (opA),
        .opB      (opB),
        .subtract (subtract),
        .result   (result),
        .busy     (busy),
        .done     (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Whole-run limit
    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    function automatic logic [7:0] clampExp(input int value);
        if (value < 1)
            return 8'd1;
        if (value > 254)
            return 8'd254;
        return 8'(value);
    endfunction

    // Keeps sign and fraction, moves the exponent into the normal range
    function automatic logic [31:0] forceNormal(input logic [31:0] word);
        return {word[31], clampExp(int'(word[30:23])), word[22:0]};
    endfunction

    // Flush, 26-place cap with sticky, nearest even, overflow to infinity, underflow to +0
    function automatic logic [31:0] refAdd(input logic [31:0] a, input logic [31:0] b,
                                           input logic sub);
        logic        signA, signB, signBig, stick, rndUp;
        logic [7:0]  expA, expB;
        logic [23:0] mantA, mantB, mantBig, mantSmall;
        logic [49:0] window;
        logic [27:0] total;
        logic [26:0] mag;
        logic [24:0] kept;
        int          shift;
        int          e;
        signA = a[31];
        signB = b[31] ^ sub;
        expA  = a[30:23];
        expB  = b[30:23];
        mantA = (expA == 8'd0) ? 24'd0 : {1'b1, a[22:0]};
        mantB = (expB == 8'd0) ? 24'd0 : {1'b1, b[22:0]};
        if ({expA, mantA} >= {expB, mantB})
        begin
            signBig   = signA;
            e         = expA;
            shift     = int'(expA) - int'(expB);
            mantBig   = mantA;
            mantSmall = mantB;
        end
        else
        begin
            signBig   = signB;
            e         = expB;
            shift     = int'(expB) - int'(expA);
            mantBig   = mantB;
            mantSmall = mantA;
        end
        if (shift > 26)
            shift = 26;
        window = {mantSmall, 26'd0} >> shift;
        stick  = |window[23:0];
        if (signA ^ signB)
            total = {1'b0, mantBig, 3'b000} - {1'b0, window[49:24], stick};
        else
            total = {1'b0, mantBig, 3'b000} + {1'b0, window[49:24], stick};
        if (total[27])
        begin
            mag = {total[27:2], |total[1:0]};
            e++;
        end
        else
            mag = total[26:0];
        if (mag == 27'd0)
            return 32'h0;
        while (!mag[26])
        begin
            mag = mag << 1;
            e--;
        end
        rndUp = mag[2] && (mag[1] || mag[0] || mag[3]);
        kept  = {1'b0, mag[26:3]} + {24'd0, rndUp};
        if (kept[24])
        begin
            kept = kept >> 1;
            e++;
        end
        if (e < 1)
            return 32'h0;
        if (e >= 255)
            return {signBig, 8'hff, 23'd0};
        return {signBig, e[7:0], kept[22:0]};
    endfunction

    // One operation; with poke set a second start is sent while busy
    task automatic runOp(input string name, input logic [31:0] a, input logic [31:0] b,
                         input logic sub, input bit poke);
        logic [31:0] expected;
        int          diff;
        int          expLatency;
        int          n;
        bit          seenDone;
        expected   = refAdd(a, b, sub);
        diff       = (a[30:23] > b[30:23]) ? (a[30:23] - b[30:23]) : (b[30:23] - a[30:23]);
        expLatency = 3 + ((diff > 26) ? 26 : diff);
        @(posedge clk);
        start    <= 1'b1;
        opA.raw  <= a;
        opB.raw  <= b;
        subtract <= sub;
        @(posedge clk);
        start    <= 1'b0;
        n        = 0;
        seenDone = 1'b0;
        while (!seenDone)
        begin
            @(posedge clk);
            n++;
            if (poke && (n == 1))
            begin
                start   <= 1'b1;
                opA.raw <= 32'h42280000;
                opB.raw <= 32'hc1200000;
            end
            if (poke && (n == 2))
                start <= 1'b0;
            assert (busy)
            else
            begin
                $display("FAIL %s busy expected 1 actual 0 (cycle %0d)", name, n);
                errors++;
            end
            seenDone = done;
        end
        assert (result.raw == expected)
        else
        begin
            $display("FAIL %s result expected %h actual %h", name, expected, result.raw);
            errors++;
        end
        assert ((n - 1) == expLatency)
        else
        begin
            $display("FAIL %s latency expected %0d actual %0d", name, expLatency, n - 1);
            errors++;
        end
        if (poke)
        begin
            repeat (8)
            begin
                @(posedge clk);
                assert (!done)
                else
                begin
                    $display("FAIL %s extra done expected 0 actual 1", name);
                    errors++;
                end
            end
        end
        opsRun++;
    endtask

    task automatic reportTest(input string name, input int opsBefore, input int errBefore);
        testsRun++;
        $display("%-10s ops %0d errors %0d", name, opsRun - opsBefore, errors - errBefore);
    endtask

    initial
    begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        int          opsMark;
        int          errMark;
        rst        = 1'b1;
        start      = 1'b0;
        subtract   = 1'b0;
        opA        = '0;
        opB        = '0;
        errors     = 0;
        opsRun     = 0;
        testsRun   = 0;
        cycleCount = 0;
        rngState   = 32'h91fb333e;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;

        opsMark = opsRun;
        errMark = errors;
        runOp("one+one", 32'h3f800000, 32'h3f800000, 1'b0, 1'b0);
        runOp("1.5-0.25", 32'h3fc00000, 32'h3e800000, 1'b1, 1'b0);
        runOp("sameExp", 32'h3fc00000, 32'h3fa00000, 1'b0, 1'b0);
        runOp("3.0-1.5", 32'h40400000, 32'h3fc00000, 1'b1, 1'b0);
        runOp("tieEven", 32'h3f800000, 32'h33800000, 1'b0, 1'b0);
        runOp("neg+pos", 32'hc0200000, 32'h3f800000, 1'b0, 1'b0);
        reportTest("directed", opsMark, errMark);

        opsMark = opsRun;
        errMark = errors;
        for (int i = 0; i < 200; i++)
        begin
            r = nextRand();
            a = forceNormal(r);
            r = nextRand();
            b = forceNormal(r);
            // Every other pair keeps exponents close so real alignment happens
            if ((i % 2) == 0)
                b[30:23] = clampExp(int'(a[30:23]) + int'(r[18:16]) - 3);
            r = nextRand();
            runOp($sformatf("random[%0d]", i), a, b, r[24], 1'b0);
        end
        reportTest("random", opsMark, errMark);

        opsMark = opsRun;
        errMark = errors;
        runOp("x-x", 32'h4049cafe, 32'h4049cafe, 1'b1, 1'b0);
        runOp("x+negx", 32'hc1234567, 32'h41234567, 1'b0, 1'b0);
        runOp("denorm+1", 32'h00400000, 32'h3f800000, 1'b0, 1'b0);
        runOp("denorm2", 32'h007fffff, 32'h80123456, 1'b1, 1'b0);
        reportTest("zeros", opsMark, errMark);

        opsMark = opsRun;
        errMark = errors;
        runOp("ovfPos", 32'h7f7fffff, 32'h7f7fffff, 1'b0, 1'b0);
        runOp("ovfNeg", 32'hff7fffff, 32'h7f7fffff, 1'b1, 1'b0);
        runOp("udfLsb", 32'h00800001, 32'h00800000, 1'b1, 1'b0);
        runOp("udfHalf", 32'h00c00000, 32'h00800000, 1'b1, 1'b0);
        reportTest("range", opsMark, errMark);

        opsMark = opsRun;
        errMark = errors;
        runOp("lat0", 32'h3f800000, 32'h3f000000 | 32'h00800000, 1'b0, 1'b0);
        runOp("lat1", 32'h40000000, 32'h3f800000, 1'b0, 1'b0);
        runOp("lat5", 32'h42000000, 32'h3f800000, 1'b1, 1'b0);
        runOp("lat26", 32'h4c800000, 32'h3f800000, 1'b0, 1'b0);
        runOp("lat100", 32'h71800000, 32'h3f800000, 1'b0, 1'b0);
        reportTest("latency", opsMark, errMark);

        opsMark = opsRun;
        errMark = errors;
        runOp("busyStart", 32'h40a00000, 32'h3fc00000, 1'b0, 1'b1);
        reportTest("busy", opsMark, errMark);

        errors += u_fpAdder.u_checker.failCount;
        $display("Tests %0d, operations %0d, errors %0d", testsRun, opsRun, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/fpAdder_checker.sv */
// Concurrent checks on the fpAdder ports and the bind that attaches them
`timescale 1ns/1ns
`default_nettype none

module fpAdderChecker (
    input logic        clk,
    input logic        rst,
    input logic        busy,
    input logic        done,
    input logic [31:0] result
);

    int failCount = 0;

    // done is a one-cycle pulse
    doneSingle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else
    begin
        $error("done stayed high for more than one cycle");
        failCount++;
    end

    // done only closes an operation that was already running
    doneInBusy: assert property (@(posedge clk) disable iff (rst) done |-> $past(busy))
    else
    begin
        $error("done seen without busy high in the cycle before");
        failCount++;
    end

    // Idle outputs straight out of reset
    resetIdle: assert property (@(posedge clk) rst |=> (!busy && !done && (result == '0)))
    else
    begin
        $error("busy, done or result not cleared by reset");
        failCount++;
    end

    // Result moves only on the edge that raises done
    resultHold: assert property (@(posedge clk) disable iff (rst) !$stable(result) |-> done)
    else
    begin
        $error("result changed outside a done pulse");
        failCount++;
    end

endmodule

bind fpAdder fpAdderChecker u_checker (
    .clk    (clk),
    .rst    (rst),
    .busy   (busy),
    .done   (done),
    .result (result)
);

`default_nettype wire
